// File: tb.f
hw/regReadPkg.sv
hw/physRegFile.sv
hw/operandBypass.sv
hw/regReadLane.sv
hw/readyTable.sv
hw/regRead.sv
verif/tbClock.sv
verif/regReadTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the register-read testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module regReadTb \
  -Mdir obj_dir \
  -o regReadSim

# The simulator exits nonzero on a failed check; the log decides the result.
./obj_dir/regReadSim > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: verif/regReadTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the register-read stage.
// one table row per cycle, driven on the falling edge.
// comb outputs checked 1 ns after driving, ready bits after the rising edge.
// preload rows fill the whole file before any data is checked.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module regReadTb
  import regReadPkg::*;
();

  typedef struct packed {
    issuePktT  [ISSUE_WIDTH-1:0] issue;
    laneMaskT                    issueValid;
    bypassPktT [ISSUE_WIDTH-1:0] bypass;
    laneMaskT                    bypassValid;
    tagStrobeT [ISSUE_WIDTH-1:0] unmap;
    tagStrobeT [ISSUE_WIDTH-1:0] wakeup;
    logic                        verified;
    logic                        mispredict;
    ckptIdT                      ckptId;
    logic                        recover;
    logic                        exception;
    dataT      [ISSUE_WIDTH-1:0] expData1;  // expected side from here.
    dataT      [ISSUE_WIDTH-1:0] expData2;
    laneMaskT                    expValid;
    logic      [PHYS_REGS-1:0]   expReady;
    logic                        checkData;
  } rowT;

  logic                         clk;
  logic                         rstN;
  rowT                          stim;
  readPktT   [ISSUE_WIDTH-1:0]  readOut;
  laneMaskT                     readValid;
  logic      [PHYS_REGS-1:0]    physReady;

  rowT                          rows [$];
  string                        rowNames [$];
  dataT                         fileModel [PHYS_REGS];
  logic      [PHYS_REGS-1:0]    readyModel;

  tbClock u_tbClock (
    .clk_o  (clk),
    .rstN_o (rstN)
  );

  regRead u_regRead (
    .clk              (clk),
    .rstN_i           (rstN),
    .issue_i          (stim.issue),
    .issueValid_i     (stim.issueValid),
    .bypass_i         (stim.bypass),
    .bypassValid_i    (stim.bypassValid),
    .unmap_i          (stim.unmap),
    .wakeup_i         (stim.wakeup),
    .ctrlVerified_i   (stim.verified),
    .ctrlMispredict_i (stim.mispredict),
    .ctrlCkptId_i     (stim.ckptId),
    .recover_i        (stim.recover),
    .exception_i      (stim.exception),
    .read_o           (readOut),
    .readValid_o      (readValid),
    .physReady_o      (physReady)
  );

  task automatic stopOnTimeout(input string what);
    $display("Timeout: %s", what);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped after a timeout");
  endtask

  task automatic checkValue(input string name, input string what,
                            input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // returns just after the requested clock edge.
  task automatic waitEdge(input logic level);
    int events;
    events = 0;
    do begin
      @(clk);
      events++;
    end while (clk !== level && events < 4);
    if (clk !== level) stopOnTimeout("clock edge not seen");
  endtask

  task automatic waitReset();
    int edges;
    edges = 0;
    while (rstN !== 1'b1 && edges < 20) begin
      waitEdge(1'b1);
      edges++;
    end
    if (rstN !== 1'b1) stopOnTimeout("reset was never released");
  endtask

  function automatic logic [PHYS_REGS-1:0] archPattern();
    logic [PHYS_REGS-1:0] pattern;
    pattern = '0;
    for (int i = 0; i < ARCH_REGS; i++) pattern[i] = 1'b1;
    return pattern;
  endfunction

  function automatic tagStrobeT tagStrobe(input physTagT tag);
    tagStrobeT s;
    s.valid = 1'b1;
    s.tag   = tag;
    return s;
  endfunction

  // lowest matching bypass lane, else the file.
  function automatic dataT expectOperand(input rowT r, input physTagT tag);
    dataT value;
    logic found;
    value = fileModel[tag];
    found = 1'b0;
    for (int b = 0; b < ISSUE_WIDTH; b++) begin
      if (!found && r.bypassValid[b] && r.bypass[b].dest == tag) begin
        value = r.bypass[b].data;
        found = 1'b1;
      end
    end
    return value;
  endfunction

  // fills in the expected values, then advances the models.
  task automatic pushRow(input string name, input rowT r, input logic checkData,
                         input laneMaskT survivors = '1);
    r.checkData = checkData;
    r.expValid  = r.issueValid & survivors;
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      r.expData1[l] = expectOperand(r, r.issue[l].src1);
      r.expData2[l] = expectOperand(r, r.issue[l].src2);
    end
    if (!r.recover) begin
      for (int b = 0; b < ISSUE_WIDTH; b++) begin
        if (r.bypassValid[b]) fileModel[r.bypass[b].dest] = r.bypass[b].data;
      end
    end
    if (r.exception) begin
      readyModel = archPattern();
    end else begin
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (r.unmap[l].valid) readyModel[r.unmap[l].tag] = 1'b0;
      end
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (r.wakeup[l].valid) readyModel[r.wakeup[l].tag] = 1'b1;  // set wins.
      end
    end
    r.expReady = readyModel;
    rows.push_back(r);
    rowNames.push_back(name);
  endtask

  // survivors lists the lanes that should stay valid.
  task automatic addSquashRow(input string name, input logic verified,
                              input logic mispredict, input ckptIdT id,
                              input laneMaskT survivors);
    rowT r;
    r = '0;
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      r.issue[l].src1    = physTagT'($urandom);
      r.issue[l].src2    = physTagT'($urandom);
      r.issue[l].payload = payloadT'($urandom);
    end
    r.issue[0].branchMask = 4'b0001;
    r.issue[1].branchMask = 4'b0010;
    r.issue[2].branchMask = 4'b0011;
    r.issue[3].branchMask = 4'b1000;
    r.issueValid = '1;
    r.verified   = verified;
    r.mispredict = mispredict;
    r.ckptId     = id;
    pushRow(name, r, 1'b1, survivors);
  endtask

  task automatic buildTable();
    rowT     r;
    physTagT t;
    readyModel = archPattern();
    r = '0;
    pushRow("readyAfterReset", r, 1'b0);
    for (int g = 0; g < PHYS_REGS / ISSUE_WIDTH; g++) begin
      r = '0;
      for (int b = 0; b < ISSUE_WIDTH; b++) begin
        r.bypass[b].dest = physTagT'(ISSUE_WIDTH * g + b);
        r.bypass[b].data = $urandom;
      end
      r.bypassValid = '1;
      pushRow("preload", r, 1'b0);
    end
    for (int g = 0; g < PHYS_REGS / READ_PORTS; g++) begin
      r = '0;
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        r.issue[l].src1       = physTagT'(READ_PORTS * g + 2 * l);
        r.issue[l].src2       = physTagT'(READ_PORTS * g + 2 * l + 1);
        r.issue[l].payload    = payloadT'($urandom);
        r.issue[l].branchMask = ckptMaskT'($urandom);
      end
      r.issueValid = '1;
      pushRow("readback", r, 1'b1);
    end
    // every issue lane and both operands from one bypass lane.
    for (int b = 0; b < ISSUE_WIDTH; b++) begin
      r = '0;
      t = physTagT'($urandom);
      r.bypass[b].dest  = t;
      r.bypass[b].data  = $urandom;
      r.bypassValid[b]  = 1'b1;
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        r.issue[l].src1    = t;
        r.issue[l].src2    = t;
        r.issue[l].payload = payloadT'($urandom);
      end
      r.issueValid = '1;
      pushRow($sformatf("fwdLane%0d", b), r, 1'b1);
    end
    r = '0;
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      r.bypass[l].dest = physTagT'(20 + l);
      r.bypass[l].data = $urandom;
      r.issue[l].src1  = physTagT'(20 + l);
      r.issue[l].src2  = physTagT'(20 + (l + 1) % ISSUE_WIDTH);
    end
    r.bypassValid = '1;
    r.issueValid  = '1;
    pushRow("fwdMixed", r, 1'b1);
    r = '0;
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      r.issue[l].src1 = physTagT'(20 + l);
      r.issue[l].src2 = physTagT'(20 + (l + 3) % ISSUE_WIDTH);
    end
    r.issueValid = '1;
    pushRow("fwdReadback", r, 1'b1);
    // recover keeps the old file value.
    r = '0;
    r.bypass[2].dest = physTagT'(50);
    r.bypass[2].data = $urandom;
    r.bypassValid[2] = 1'b1;
    r.recover        = 1'b1;
    r.issue[0].src1  = physTagT'(50);
    r.issue[0].src2  = physTagT'(51);
    r.issueValid[0]  = 1'b1;
    pushRow("recoverFwd", r, 1'b1);
    r = '0;
    r.issue[0].src1 = physTagT'(50);
    r.issueValid[0] = 1'b1;
    pushRow("recoverHold", r, 1'b1);
    addSquashRow("squashCkpt1", 1'b1, 1'b1, 2'd1, 4'b1001);
    addSquashRow("squashCkpt0", 1'b1, 1'b1, 2'd0, 4'b1010);
    addSquashRow("squashCkpt3", 1'b1, 1'b1, 2'd3, 4'b0111);
    addSquashRow("unverified", 1'b0, 1'b1, 2'd1, 4'b1111);
    addSquashRow("noMispredict", 1'b1, 1'b0, 2'd0, 4'b1111);
    r = '0;
    r.unmap[0] = tagStrobe(physTagT'(5));
    r.unmap[3] = tagStrobe(physTagT'(10));
    pushRow("unmapClear", r, 1'b1);
    r = '0;
    r.wakeup[0] = tagStrobe(physTagT'(40));
    r.wakeup[1] = tagStrobe(physTagT'(5));
    r.wakeup[2] = tagStrobe(physTagT'(41));
    r.wakeup[3] = tagStrobe(physTagT'(10));
    pushRow("wakeupSet", r, 1'b1);
    r = '0;
    r.unmap[0]  = tagStrobe(physTagT'(6));
    r.unmap[1]  = tagStrobe(physTagT'(40));
    r.wakeup[2] = tagStrobe(physTagT'(40));
    pushRow("setBeatsClear", r, 1'b1);
    r = '0;
    r.exception = 1'b1;
    r.wakeup[0] = tagStrobe(physTagT'(50));
    pushRow("exceptionRestore", r, 1'b1);
    r = '0;
    pushRow("afterException", r, 1'b1);
  endtask

  task automatic checkComb(input int i);
    rowT   r;
    string name;
    r    = rows[i];
    name = rowNames[i];
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      checkValue(name, $sformatf("lane%0d valid", l), 64'(r.expValid[l]), 64'(readValid[l]));
      checkValue(name, $sformatf("lane%0d issue", l), 64'(r.issue[l]), 64'(readOut[l].issue));
      if (r.checkData) begin
        checkValue(name, $sformatf("lane%0d data1", l), 64'(r.expData1[l]),
                   64'(readOut[l].data1));
        checkValue(name, $sformatf("lane%0d data2", l), 64'(r.expData2[l]),
                   64'(readOut[l].data2));
      end
    end
  endtask

  initial begin
    stim = '0;
    void'($urandom(32'h944c5634));
    buildTable();
    waitReset();
    for (int i = 0; i < rows.size(); i++) begin
      waitEdge(1'b0);
      stim = rows[i];
      #1;
      checkComb(i);
      waitEdge(1'b1);
      #1;  // ready table has taken the edge.
      checkValue(rowNames[i], "physReady", rows[i].expReady, physReady);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tbClock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 10 ns clock, reset low for 5 cycles.
// reset is released on a falling edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk_o,
  output logic rstN_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rstN_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rstN_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: hw/regRead.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register-read stage of a four-wide core.
// zero-latency from issue to read packet.
// recover blocks file writes but not forwarding.
// no back-pressure; every valid is a strobe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module regRead
  import regReadPkg::*;
(
  input  wire                                clk,
  input  wire                                rstN_i,
  input  issuePktT  [ISSUE_WIDTH-1:0]        issue_i,
  input  laneMaskT                           issueValid_i,
  input  bypassPktT [ISSUE_WIDTH-1:0]        bypass_i,
  input  laneMaskT                           bypassValid_i,
  input  tagStrobeT [ISSUE_WIDTH-1:0]        unmap_i,
  input  tagStrobeT [ISSUE_WIDTH-1:0]        wakeup_i,
  input  wire                                ctrlVerified_i,
  input  wire                                ctrlMispredict_i,
  input  ckptIdT                             ctrlCkptId_i,
  input  wire                                recover_i,
  input  wire                                exception_i,
  output readPktT   [ISSUE_WIDTH-1:0]        read_o,
  output laneMaskT                           readValid_o,
  output logic      [PHYS_REGS-1:0]          physReady_o
);

  physTagT [READ_PORTS-1:0]  rdTag;
  dataT    [READ_PORTS-1:0]  rdData;
  laneMaskT                  wrEn;
  physTagT [ISSUE_WIDTH-1:0] wrTag;
  dataT    [ISSUE_WIDTH-1:0] wrData;
  logic                      mispredict;

  assign mispredict = ctrlVerified_i && ctrlMispredict_i;
  assign wrEn       = bypassValid_i & ~{ISSUE_WIDTH{recover_i}};

  // lane l uses read ports 2l and 2l+1.
  always_comb begin
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      rdTag[2*l]   = issue_i[l].src1;
      rdTag[2*l+1] = issue_i[l].src2;
      wrTag[l]     = bypass_i[l].dest;
      wrData[l]    = bypass_i[l].data;
    end
  end

  physRegFile u_physRegFile (
    .clk      (clk),
    .rdTag_i  (rdTag),
    .rdData_o (rdData),
    .wrEn_i   (wrEn),
    .wrTag_i  (wrTag),
    .wrData_i (wrData)
  );

  for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_lane
    regReadLane u_lane (
      .pkt_i          (issue_i[l]),
      .valid_i        (issueValid_i[l]),
      .fileData1_i    (rdData[2*l]),
      .fileData2_i    (rdData[2*l+1]),
      .bypassValid_i  (bypassValid_i),
      .bypass_i       (bypass_i),
      .mispredict_i   (mispredict),
      .mispredictId_i (ctrlCkptId_i),
      .pkt_o          (read_o[l]),
      .valid_o        (readValid_o[l])
    );
  end

  readyTable u_readyTable (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .exception_i (exception_i),
    .unmap_i     (unmap_i),
    .wakeup_i    (wakeup_i),
    .ready_o     (physReady_o)
  );

endmodule

`default_nettype wire

// File: hw/readyTable.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one ready bit per physical register.
// reset or exception loads the architectural map.
// a wakeup beats an unmap of the same tag.
// output is the registered state.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module readyTable
  import regReadPkg::*;
(
  input  wire                                clk,
  input  wire                                rstN_i,
  input  wire                                exception_i,
  input  tagStrobeT [ISSUE_WIDTH-1:0]        unmap_i,
  input  tagStrobeT [ISSUE_WIDTH-1:0]        wakeup_i,
  output logic      [PHYS_REGS-1:0]          ready_o
);

  logic [PHYS_REGS-1:0] readyQ;
  logic [PHYS_REGS-1:0] readyNext;

  always_comb begin
    readyNext = readyQ;
    // clears first, sets after.
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      if (unmap_i[l].valid) begin
        readyNext[unmap_i[l].tag] = 1'b0;
      end
    end
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      if (wakeup_i[l].valid) begin
        readyNext[wakeup_i[l].tag] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i || exception_i) begin
      readyQ <= ARCH_READY;
    end else begin
      readyQ <= readyNext;
    end
  end

  assign ready_o = readyQ;

endmodule

`default_nettype wire

// File: hw/regReadLane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one issue lane, fully combinational.
// squash needs an already verified mispredict.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module regReadLane
  import regReadPkg::*;
(
  input  issuePktT                           pkt_i,
  input  wire                                valid_i,
  input  dataT                               fileData1_i,
  input  dataT                               fileData2_i,
  input  laneMaskT                           bypassValid_i,
  input  bypassPktT [ISSUE_WIDTH-1:0]        bypass_i,
  input  wire                                mispredict_i,
  input  ckptIdT                             mispredictId_i,
  output readPktT                            pkt_o,
  output logic                               valid_o
);

  dataT opData1;
  dataT opData2;
  logic squash;

  operandBypass u_src1 (
    .srcTag_i      (pkt_i.src1),
    .fileData_i    (fileData1_i),
    .bypassValid_i (bypassValid_i),
    .bypass_i      (bypass_i),
    .data_o        (opData1)
  );

  operandBypass u_src2 (
    .srcTag_i      (pkt_i.src2),
    .fileData_i    (fileData2_i),
    .bypassValid_i (bypassValid_i),
    .bypass_i      (bypass_i),
    .data_o        (opData2)
  );

  // instruction sits behind the mispredicted branch.
  assign squash  = mispredict_i && pkt_i.branchMask[mispredictId_i];
  assign valid_o = valid_i && !squash;

  always_comb begin
    pkt_o.issue = pkt_i;  // payload passes unchanged.
    pkt_o.data1 = opData1;
    pkt_o.data2 = opData2;
  end

endmodule

`default_nettype wire

// File: hw/operandBypass.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one source operand: bypass lane or file read.
// more than one matching lane is illegal;
// the lowest-numbered match is taken then.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module operandBypass
  import regReadPkg::*;
(
  input  physTagT                            srcTag_i,
  input  dataT                               fileData_i,
  input  laneMaskT                           bypassValid_i,
  input  bypassPktT [ISSUE_WIDTH-1:0]        bypass_i,
  output dataT                               data_o
);

  laneMaskT match;

  // tag equality and lane valid.
  always_comb begin
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      match[l] = bypassValid_i[l] && (bypass_i[l].dest == srcTag_i);
    end
  end

  // walk down so lane 0 has the last word.
  always_comb begin
    data_o = fileData_i;
    for (int l = ISSUE_WIDTH - 1; l >= 0; l--) begin
      if (match[l]) begin
        data_o = bypass_i[l].data;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/physRegFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64-entry register array, 8 async reads, 4 writes.
// a write shows up on reads after the edge only.
// same-tag writes in one cycle are illegal; highest port wins.
// contents are not reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module physRegFile
  import regReadPkg::*;
(
  input  wire                                clk,
  input  physTagT  [READ_PORTS-1:0]          rdTag_i,
  output dataT     [READ_PORTS-1:0]          rdData_o,
  input  laneMaskT                           wrEn_i,
  input  physTagT  [ISSUE_WIDTH-1:0]         wrTag_i,
  input  dataT     [ISSUE_WIDTH-1:0]         wrData_i
);

  dataT regs [PHYS_REGS];

  // later ports overwrite earlier ones in the loop.
  always_ff @(posedge clk) begin
    for (int w = 0; w < ISSUE_WIDTH; w++) begin
      if (wrEn_i[w]) begin
        regs[wrTag_i[w]] <= wrData_i[w];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < READ_PORTS; r++) begin
      rdData_o[r] = regs[rdTag_i[r]];  // no bypass here.
    end
  end

endmodule

`default_nettype wire

// File: hw/regReadPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes and packet types of the register-read stage.
// one 32-bit data slice, no SRAM split.
// the opaque payload carries the issue fields that pass through untouched.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package regReadPkg;

  localparam int ISSUE_WIDTH     = 4;
  localparam int READ_PORTS      = 2 * ISSUE_WIDTH;  // two sources per lane.
  localparam int PHYS_REGS       = 64;
  localparam int PHYS_TAG_W      = $clog2(PHYS_REGS);
  localparam int ARCH_REGS       = 32;
  localparam int CHECKPOINTS     = 4;
  localparam int CHECKPOINTS_LOG = $clog2(CHECKPOINTS);
  localparam int DATA_W          = 32;
  localparam int PAYLOAD_W       = 16;

  // architectural mapping after reset or exception.
  localparam logic [PHYS_REGS-1:0] ARCH_READY =
    {{(PHYS_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};

  typedef logic [PHYS_TAG_W-1:0]      physTagT;
  typedef logic [DATA_W-1:0]          dataT;
  typedef logic [CHECKPOINTS-1:0]     ckptMaskT;
  typedef logic [CHECKPOINTS_LOG-1:0] ckptIdT;
  typedef logic [ISSUE_WIDTH-1:0]     laneMaskT;
  typedef logic [PAYLOAD_W-1:0]       payloadT;

  // issued instruction, cut down to what this stage looks at.
  typedef struct packed {
    ckptMaskT branchMask;
    physTagT  src1;
    physTagT  src2;
    payloadT  payload;
  } issuePktT;

  // issue packet with both operands attached.
  typedef struct packed {
    issuePktT issue;
    dataT     data1;
    dataT     data2;
  } readPktT;

  // writeback result; valid travels beside it.
  typedef struct packed {
    physTagT dest;
    dataT    data;
  } bypassPktT;

  // unmap and wakeup tags.
  typedef struct packed {
    logic    valid;
    physTagT tag;
  } tagStrobeT;

endpackage

`default_nettype wire
